/* logic/mhq_pkg.sv */
/*
 * Miss handling queue shared definitions
 * Widths, line and byte types and the LSU function encoding
 */

package mhq_pkg;

    parameter int MHQ_ADDR_WIDTH = 32;
    parameter int MHQ_DATA_WIDTH = 32;
    parameter int MHQ_LINE_BYTES = 16;

    // Derived line geometry
    parameter int MHQ_WORD_BYTES     = MHQ_DATA_WIDTH / 8;
    parameter int MHQ_LINE_WORDS     = MHQ_LINE_BYTES / MHQ_WORD_BYTES;
    parameter int MHQ_OFFSET_WIDTH   = $clog2(MHQ_LINE_BYTES);
    parameter int MHQ_WORD_IDX_WIDTH = $clog2(MHQ_LINE_WORDS);

    typedef logic [MHQ_ADDR_WIDTH-1:0]                  mhq_addr_t;
    typedef logic [MHQ_ADDR_WIDTH-MHQ_OFFSET_WIDTH-1:0] mhq_line_addr_t;
    typedef logic [MHQ_DATA_WIDTH-1:0]                  mhq_data_t;
    typedef logic [MHQ_WORD_BYTES-1:0]                  mhq_byte_sel_t;
    typedef logic [MHQ_LINE_BYTES*8-1:0]                mhq_line_t;
    typedef logic [MHQ_LINE_BYTES-1:0]                  mhq_line_mask_t;
    typedef logic [MHQ_WORD_IDX_WIDTH-1:0]              mhq_word_idx_t;

    // LSU operation as seen by the lookup port
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100,
        LSU_FUNC_SB  = 3'b101,
        LSU_FUNC_SH  = 3'b110,
        LSU_FUNC_SW  = 3'b111
    } mhq_lsu_func_t;

endpackage

/* logic/mhq_lookup.sv */
/*
 * MHQ lookup stage
 * Matches a missed address against open entries, decides merge, allocate
 * or reject, and registers the result for the execute stage
 */

`timescale 1ns/1ps

module mhq_lookup
    import mhq_pkg::*;
#(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                           clk,
    input  logic                           i_rst,

    input  logic                           i_mhq_lookup_valid,
    input  logic                           i_mhq_lookup_dc_hit,
    input  mhq_addr_t                      i_mhq_lookup_addr,
    input  mhq_lsu_func_t                  i_mhq_lookup_lsu_func,
    input  mhq_data_t                      i_mhq_lookup_data,

    input  logic [MHQ_DEPTH-1:0]           i_match_valid,
    input  mhq_line_addr_t [MHQ_DEPTH-1:0] i_entry_line_addr,
    input  logic [TAG_W:0]                 i_count,
    input  logic [TAG_W-1:0]               i_tail,

    output logic                           o_lu_en,
    output logic                           o_lu_match,
    output logic [TAG_W-1:0]               o_lu_tag,
    output mhq_line_addr_t                 o_lu_line_addr,
    output logic                           o_lu_we,
    output mhq_word_idx_t                  o_lu_offset,
    output mhq_data_t                      o_lu_wr_data,
    output mhq_byte_sel_t                  o_lu_byte_sel,
    output logic                           o_lookup_full
);

    logic                 lookup_en;
    mhq_line_addr_t       lookup_line;
    logic                 cam_hit;
    logic [TAG_W-1:0]     cam_tag;
    logic                 alloc_pending;
    logic                 bypass_hit;
    logic                 hit;
    logic                 full;
    logic [TAG_W-1:0]     next_tag;
    logic                 we;
    mhq_byte_sel_t        byte_sel;
    mhq_data_t            wr_data;

    assign lookup_en   = i_mhq_lookup_valid & ~i_mhq_lookup_dc_hit;
    assign lookup_line = i_mhq_lookup_addr[MHQ_ADDR_WIDTH-1:MHQ_OFFSET_WIDTH];

    // Only entries not yet sent to the CCU take part in the match
    always_comb begin
        cam_hit = 1'b0;
        cam_tag = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (i_match_valid[i] && (i_entry_line_addr[i] == lookup_line)) begin
                cam_hit = 1'b1;
                cam_tag = TAG_W'(i);
            end
        end
    end

    // The registered result is written one cycle later, so a lookup to the
    // same line in the next cycle has to see it here
    assign alloc_pending = o_lu_en & ~o_lu_match;
    assign bypass_hit    = o_lu_en && (o_lu_line_addr == lookup_line) &&
                           (alloc_pending || i_match_valid[o_lu_tag]);
    assign hit           = cam_hit | bypass_hit;

    // Retirements in this cycle are not counted, so full may be early
    assign full = (i_count == (TAG_W+1)'(MHQ_DEPTH)) ||
                  ((i_count == (TAG_W+1)'(MHQ_DEPTH - 1)) && alloc_pending);

    always_comb begin
        if (bypass_hit) begin
            next_tag = o_lu_tag;
        end else if (cam_hit) begin
            next_tag = cam_tag;
        end else if (alloc_pending) begin
            next_tag = i_tail + 1'b1;
        end else begin
            next_tag = i_tail;
        end
    end

    // Store data is shifted into its byte lanes within the word
    always_comb begin
        we       = 1'b0;
        byte_sel = '0;
        wr_data  = i_mhq_lookup_data;
        case (i_mhq_lookup_lsu_func)
            LSU_FUNC_SB: begin
                we       = 1'b1;
                byte_sel = mhq_byte_sel_t'(1) << i_mhq_lookup_addr[1:0];
                wr_data  = i_mhq_lookup_data << {i_mhq_lookup_addr[1:0], 3'b000};
            end
            LSU_FUNC_SH: begin
                we       = 1'b1;
                byte_sel = mhq_byte_sel_t'(3) << {i_mhq_lookup_addr[1], 1'b0};
                wr_data  = i_mhq_lookup_data << {i_mhq_lookup_addr[1], 4'b0000};
            end
            LSU_FUNC_SW: begin
                we       = 1'b1;
                byte_sel = '1;
            end
            default: begin
                we       = 1'b0;
                byte_sel = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_lu_en       <= 1'b0;
            o_lu_tag      <= '0;
            o_lookup_full <= 1'b0;
        end else begin
            o_lu_en <= lookup_en && (hit || !full);
            if (lookup_en) begin
                o_lu_tag      <= next_tag;
                o_lookup_full <= !hit && full;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            o_lu_match     <= hit;
            o_lu_line_addr <= lookup_line;
            o_lu_we        <= we;
            o_lu_offset    <= i_mhq_lookup_addr[MHQ_OFFSET_WIDTH-1:2];
            o_lu_wr_data   <= wr_data;
            o_lu_byte_sel  <= byte_sel;
        end
    end

endmodule

/* logic/mhq_execute.sv */
/*
 * MHQ execute stage
 * Holds the queue entries, allocates at the tail, merges store bytes
 * and frees the head once its fill has gone out
 */

`timescale 1ns/1ps

module mhq_execute
    import mhq_pkg::*;
#(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic                           clk,
    input  logic                           i_rst,

    input  logic                           i_lu_en,
    input  logic                           i_lu_match,
    input  logic [TAG_W-1:0]               i_lu_tag,
    input  mhq_line_addr_t                 i_lu_line_addr,
    input  logic                           i_lu_we,
    input  mhq_word_idx_t                  i_lu_offset,
    input  mhq_data_t                      i_lu_wr_data,
    input  mhq_byte_sel_t                  i_lu_byte_sel,

    input  logic                           i_issue,
    input  logic                           i_retire,

    output logic [MHQ_DEPTH-1:0]           o_match_valid,
    output mhq_line_addr_t [MHQ_DEPTH-1:0] o_entry_line_addr,
    output logic [TAG_W:0]                 o_count,
    output logic [TAG_W-1:0]               o_tail,

    output logic                           o_head_valid,
    output logic [TAG_W-1:0]               o_head_tag,
    output mhq_line_addr_t                 o_head_line_addr,
    output mhq_line_t                      o_head_data,
    output mhq_line_mask_t                 o_head_mask
);

    logic [MHQ_DEPTH-1:0]           entry_valid;
    logic [MHQ_DEPTH-1:0]           entry_issued;
    mhq_line_addr_t [MHQ_DEPTH-1:0] entry_addr;
    mhq_line_t                      entry_data [MHQ_DEPTH];
    mhq_line_mask_t                 entry_mask [MHQ_DEPTH];

    logic [TAG_W-1:0]               head;
    logic [TAG_W-1:0]               tail;
    logic [TAG_W:0]                 count;

    logic                           alloc;
    mhq_line_t                      wr_line;
    mhq_line_mask_t                 wr_mask;

    assign alloc = i_lu_en & ~i_lu_match;

    // The store word is copied to every word slot and the mask picks the right one
    assign wr_line = {MHQ_LINE_WORDS{i_lu_wr_data}};
    assign wr_mask = i_lu_we ?
                     (mhq_line_mask_t'(i_lu_byte_sel) << {i_lu_offset, 2'b00}) : '0;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            entry_valid  <= '0;
            entry_issued <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
        end else begin
            if (alloc) begin
                entry_valid[i_lu_tag]  <= 1'b1;
                entry_issued[i_lu_tag] <= 1'b0;
                tail                   <= tail + 1'b1;
            end

            if (i_issue) begin
                entry_issued[head] <= 1'b1;
            end

            if (i_retire) begin
                entry_valid[head] <= 1'b0;
                head              <= head + 1'b1;
            end

            count <= count + (TAG_W+1)'(alloc) - (TAG_W+1)'(i_retire);
        end
    end

    // A fresh entry starts with only the bytes of its own store marked
    always_ff @(posedge clk) begin
        if (i_lu_en) begin
            if (alloc) begin
                entry_addr[i_lu_tag] <= i_lu_line_addr;
                entry_mask[i_lu_tag] <= wr_mask;
            end else begin
                entry_mask[i_lu_tag] <= entry_mask[i_lu_tag] | wr_mask;
            end

            for (int b = 0; b < MHQ_LINE_BYTES; b++) begin
                if (wr_mask[b]) begin
                    entry_data[i_lu_tag][b*8 +: 8] <= wr_line[b*8 +: 8];
                end
            end
        end
    end

    assign o_match_valid     = entry_valid & ~entry_issued;
    assign o_entry_line_addr = entry_addr;
    assign o_count           = count;
    assign o_tail            = tail;

    // The head stays valid while in flight so the fill can read its bytes
    assign o_head_valid     = entry_valid[head];
    assign o_head_tag       = head;
    assign o_head_line_addr = entry_addr[head];
    assign o_head_data      = entry_data[head];
    assign o_head_mask      = entry_mask[head];

endmodule

/* logic/mhq_fill.sv */
/*
 * MHQ fill stage
 * Requests the head line from the CCU and merges the returned line
 * with the stored bytes onto the fill port
 */

`timescale 1ns/1ps

module mhq_fill
    import mhq_pkg::*;
#(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic               clk,
    input  logic               i_rst,

    input  logic               i_head_valid,
    input  logic [TAG_W-1:0]   i_head_tag,
    input  mhq_line_addr_t     i_head_line_addr,
    input  mhq_line_t          i_head_data,
    input  mhq_line_mask_t     i_head_mask,

    input  logic               i_ccu_done,
    input  mhq_line_t          i_ccu_data,

    output logic               o_issue,
    output logic               o_retire,
    output logic               o_ccu_en,
    output mhq_addr_t          o_ccu_addr,

    output logic               o_fill_en,
    output logic [TAG_W-1:0]   o_fill_tag,
    output logic               o_fill_dirty,
    output mhq_addr_t          o_fill_addr,
    output mhq_line_t          o_fill_data
);

    typedef enum logic {
        FILL_IDLE,
        FILL_WAIT
    } fill_state_t;

    fill_state_t state;
    mhq_line_t   merged_line;

    // One request is open at a time, always for the head entry
    assign o_issue  = (state == FILL_IDLE) & i_head_valid;
    assign o_retire = (state == FILL_WAIT) & i_ccu_done;
    assign o_ccu_en = (state == FILL_WAIT);

    // Store bytes win over memory bytes
    always_comb begin
        for (int b = 0; b < MHQ_LINE_BYTES; b++) begin
            merged_line[b*8 +: 8] = i_head_mask[b] ? i_head_data[b*8 +: 8] :
                                                     i_ccu_data[b*8 +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state     <= FILL_IDLE;
            o_fill_en <= 1'b0;
        end else begin
            o_fill_en <= o_retire;
            case (state)
                FILL_IDLE: if (i_head_valid) state <= FILL_WAIT;
                FILL_WAIT: if (i_ccu_done) state <= FILL_IDLE;
                default:   state <= FILL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_issue) begin
            o_ccu_addr <= {i_head_line_addr, {MHQ_OFFSET_WIDTH{1'b0}}};
        end

        if (o_retire) begin
            o_fill_tag   <= i_head_tag;
            o_fill_dirty <= |i_head_mask;
            o_fill_addr  <= {i_head_line_addr, {MHQ_OFFSET_WIDTH{1'b0}}};
            o_fill_data  <= merged_line;
        end
    end

endmodule

/* logic/mhq.sv */
/*
 * Miss handling queue
 * Tracks data cache line misses, merges loads and stores to open lines
 * and returns merged lines in allocation order
 */

`timescale 1ns/1ps

module mhq
    import mhq_pkg::*;
#(
    parameter  int MHQ_DEPTH = 4,
    localparam int TAG_W     = $clog2(MHQ_DEPTH)
) (
    input  logic              clk,
    input  logic              i_rst,

    // Lookup from the LSU for a load or store that missed
    input  logic              i_mhq_lookup_valid,
    input  logic              i_mhq_lookup_dc_hit,
    input  mhq_addr_t         i_mhq_lookup_addr,
    input  mhq_lsu_func_t     i_mhq_lookup_lsu_func,
    input  mhq_data_t         i_mhq_lookup_data,
    output logic [TAG_W-1:0]  o_mhq_lookup_tag,
    output logic              o_mhq_lookup_full,

    // CCU line request
    input  logic              i_ccu_done,
    input  mhq_line_t         i_ccu_data,
    output logic              o_ccu_en,
    output mhq_addr_t         o_ccu_addr,

    // Fill of the merged line into the data cache
    output logic              o_mhq_fill_en,
    output logic [TAG_W-1:0]  o_mhq_fill_tag,
    output logic              o_mhq_fill_dirty,
    output mhq_addr_t         o_mhq_fill_addr,
    output mhq_line_t         o_mhq_fill_data
);

    logic [MHQ_DEPTH-1:0]           match_valid;
    mhq_line_addr_t [MHQ_DEPTH-1:0] entry_line_addr;
    logic [TAG_W:0]                 count;
    logic [TAG_W-1:0]               tail;

    logic                           lu_en;
    logic                           lu_match;
    logic [TAG_W-1:0]               lu_tag;
    mhq_line_addr_t                 lu_line_addr;
    logic                           lu_we;
    mhq_word_idx_t                  lu_offset;
    mhq_data_t                      lu_wr_data;
    mhq_byte_sel_t                  lu_byte_sel;

    logic                           head_valid;
    logic [TAG_W-1:0]               head_tag;
    mhq_line_addr_t                 head_line_addr;
    mhq_line_t                      head_data;
    mhq_line_mask_t                 head_mask;
    logic                           issue;
    logic                           retire;

    // The registered lookup tag is what the LSU sees
    assign o_mhq_lookup_tag = lu_tag;

    mhq_lookup #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_lookup_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_mhq_lookup_valid(i_mhq_lookup_valid),
        .i_mhq_lookup_dc_hit(i_mhq_lookup_dc_hit),
        .i_mhq_lookup_addr(i_mhq_lookup_addr),
        .i_mhq_lookup_lsu_func(i_mhq_lookup_lsu_func),
        .i_mhq_lookup_data(i_mhq_lookup_data),
        .i_match_valid(match_valid),
        .i_entry_line_addr(entry_line_addr),
        .i_count(count),
        .i_tail(tail),
        .o_lu_en(lu_en),
        .o_lu_match(lu_match),
        .o_lu_tag(lu_tag),
        .o_lu_line_addr(lu_line_addr),
        .o_lu_we(lu_we),
        .o_lu_offset(lu_offset),
        .o_lu_wr_data(lu_wr_data),
        .o_lu_byte_sel(lu_byte_sel),
        .o_lookup_full(o_mhq_lookup_full)
    );

    mhq_execute #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_execute_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_lu_en(lu_en),
        .i_lu_match(lu_match),
        .i_lu_tag(lu_tag),
        .i_lu_line_addr(lu_line_addr),
        .i_lu_we(lu_we),
        .i_lu_offset(lu_offset),
        .i_lu_wr_data(lu_wr_data),
        .i_lu_byte_sel(lu_byte_sel),
        .i_issue(issue),
        .i_retire(retire),
        .o_match_valid(match_valid),
        .o_entry_line_addr(entry_line_addr),
        .o_count(count),
        .o_tail(tail),
        .o_head_valid(head_valid),
        .o_head_tag(head_tag),
        .o_head_line_addr(head_line_addr),
        .o_head_data(head_data),
        .o_head_mask(head_mask)
    );

    mhq_fill #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) mhq_fill_inst (
        .clk(clk),
        .i_rst(i_rst),
        .i_head_valid(head_valid),
        .i_head_tag(head_tag),
        .i_head_line_addr(head_line_addr),
        .i_head_data(head_data),
        .i_head_mask(head_mask),
        .i_ccu_done(i_ccu_done),
        .i_ccu_data(i_ccu_data),
        .o_issue(issue),
        .o_retire(retire),
        .o_ccu_en(o_ccu_en),
        .o_ccu_addr(o_ccu_addr),
        .o_fill_en(o_mhq_fill_en),
        .o_fill_tag(o_mhq_fill_tag),
        .o_fill_dirty(o_mhq_fill_dirty),
        .o_fill_addr(o_mhq_fill_addr),
        .o_fill_data(o_mhq_fill_data)
    );

endmodule

/* verification/mhq_tb.sv */
/*
 * MHQ testbench
 * Applies a table of LSU lookups, answers CCU requests from a memory model
 * and checks every fill against a scoreboard kept in allocation order
 */

`timescale 1ns/1ps

module mhq_tb
    import mhq_pkg::*;
();

    localparam int DEPTH      = 4;
    localparam int TAG_W      = $clog2(DEPTH);
    localparam int CLK_PERIOD = 100;
    localparam int MAX_ROWS   = 32;
    localparam int SEED       = 32'h74f2_d231;

    logic              clk = 1'b0;
    logic              i_rst;
    logic              i_mhq_lookup_valid;
    logic              i_mhq_lookup_dc_hit;
    mhq_addr_t         i_mhq_lookup_addr;
    mhq_lsu_func_t     i_mhq_lookup_lsu_func;
    mhq_data_t         i_mhq_lookup_data;
    logic [TAG_W-1:0]  o_mhq_lookup_tag;
    logic              o_mhq_lookup_full;
    logic              i_ccu_done;
    mhq_line_t         i_ccu_data;
    logic              o_ccu_en;
    mhq_addr_t         o_ccu_addr;
    logic              o_mhq_fill_en;
    logic [TAG_W-1:0]  o_mhq_fill_tag;
    logic              o_mhq_fill_dirty;
    mhq_addr_t         o_mhq_fill_addr;
    mhq_line_t         o_mhq_fill_data;

    // Stimulus table with one lookup per row
    int                num_rows = 0;
    logic              row_drain [MAX_ROWS];
    logic              row_hold [MAX_ROWS];
    logic              row_valid [MAX_ROWS];
    logic              row_dc_hit [MAX_ROWS];
    mhq_lsu_func_t     row_func [MAX_ROWS];
    mhq_addr_t         row_addr [MAX_ROWS];
    mhq_data_t         row_data [MAX_ROWS];
    logic [TAG_W-1:0]  row_tag [MAX_ROWS];
    logic              row_full [MAX_ROWS];

    // Expected fills in allocation order
    logic [TAG_W-1:0]  sb_tag [$];
    mhq_addr_t         sb_addr [$];
    mhq_line_t         sb_line [$];
    logic              sb_dirty [$];

    logic              ccu_hold;

    mhq #(
        .MHQ_DEPTH(DEPTH)
    ) uut (
        .clk(clk),
        .i_rst(i_rst),
        .i_mhq_lookup_valid(i_mhq_lookup_valid),
        .i_mhq_lookup_dc_hit(i_mhq_lookup_dc_hit),
        .i_mhq_lookup_addr(i_mhq_lookup_addr),
        .i_mhq_lookup_lsu_func(i_mhq_lookup_lsu_func),
        .i_mhq_lookup_data(i_mhq_lookup_data),
        .o_mhq_lookup_tag(o_mhq_lookup_tag),
        .o_mhq_lookup_full(o_mhq_lookup_full),
        .i_ccu_done(i_ccu_done),
        .i_ccu_data(i_ccu_data),
        .o_ccu_en(o_ccu_en),
        .o_ccu_addr(o_ccu_addr),
        .o_mhq_fill_en(o_mhq_fill_en),
        .o_mhq_fill_tag(o_mhq_fill_tag),
        .o_mhq_fill_dirty(o_mhq_fill_dirty),
        .o_mhq_fill_addr(o_mhq_fill_addr),
        .o_mhq_fill_data(o_mhq_fill_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input mhq_addr_t got, input mhq_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input mhq_line_t got, input mhq_line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    // Backing memory where every word holds its own byte address XOR a fixed pattern
    function automatic mhq_line_t memory_line(input mhq_addr_t base);
        mhq_line_t line;
        for (int w = 0; w < MHQ_LINE_BYTES / 4; w++) begin
            line[w*32 +: 32] = (base + mhq_addr_t'(4 * w)) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    function automatic int store_size(input mhq_lsu_func_t func);
        case (func)
            LSU_FUNC_SB: return 1;
            LSU_FUNC_SH: return 2;
            LSU_FUNC_SW: return 4;
            default:     return 0;
        endcase
    endfunction

    // Low bytes of the store data land at the naturally aligned line offset
    function automatic mhq_line_t apply_store(input mhq_line_t line, input mhq_lsu_func_t func,
                                              input mhq_addr_t addr, input mhq_data_t data);
        mhq_line_t result;
        int        size;
        int        first;
        result = line;
        size   = store_size(func);
        first  = int'(addr[MHQ_OFFSET_WIDTH-1:0]) & ~(size - 1);
        for (int b = 0; b < size; b++) begin
            result[(first + b)*8 +: 8] = data[b*8 +: 8];
        end
        return result;
    endfunction

    task automatic add_row(input logic drain, input logic hold, input logic valid,
                           input logic dc_hit, input mhq_lsu_func_t func, input mhq_addr_t addr,
                           input mhq_data_t data, input logic [TAG_W-1:0] tag, input logic full);
        row_drain[num_rows]  = drain;
        row_hold[num_rows]   = hold;
        row_valid[num_rows]  = valid;
        row_dc_hit[num_rows] = dc_hit;
        row_func[num_rows]   = func;
        row_addr[num_rows]   = addr;
        row_data[num_rows]   = data;
        row_tag[num_rows]    = tag;
        row_full[num_rows]   = full;
        num_rows++;
    endtask

    // A tag already in the scoreboard means the lookup merged into that entry
    task automatic record_lookup(input int r);
        mhq_addr_t base;
        int        idx;
        base = {row_addr[r][MHQ_ADDR_WIDTH-1:MHQ_OFFSET_WIDTH], {MHQ_OFFSET_WIDTH{1'b0}}};
        idx  = -1;
        foreach (sb_tag[i]) begin
            if (sb_tag[i] == row_tag[r]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            sb_tag.push_back(row_tag[r]);
            sb_addr.push_back(base);
            sb_line.push_back(memory_line(base));
            sb_dirty.push_back(1'b0);
            idx = sb_tag.size() - 1;
        end else if (sb_addr[idx] != base) begin
            abort_run($sformatf("Row %0d expects tag %0d, which holds another line",
                                r, row_tag[r]));
        end
        if (store_size(row_func[r]) > 0) begin
            sb_line[idx]  = apply_store(sb_line[idx], row_func[r], row_addr[r], row_data[r]);
            sb_dirty[idx] = 1'b1;
        end
    endtask

    task automatic check_fill();
        if (sb_tag.size() == 0) begin
            abort_run($sformatf("A fill with tag %0d arrived at %0t ns but none was expected",
                                o_mhq_fill_tag, $time));
        end else begin
            check_tag("o_mhq_fill_tag", o_mhq_fill_tag, sb_tag.pop_front());
            check_addr("o_mhq_fill_addr", o_mhq_fill_addr, sb_addr.pop_front());
            check_line("o_mhq_fill_data", o_mhq_fill_data, sb_line.pop_front());
            check_flag("o_mhq_fill_dirty", o_mhq_fill_dirty, sb_dirty.pop_front());
        end
    endtask

    task automatic wait_for_drain();
        while (sb_tag.size() != 0) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic build_table();
        // Distinct load misses take tags in tail order
        add_row(0, 0, 1, 0, LSU_FUNC_LW,  32'h0000_1000, 32'h0000_0000, 2'd0, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_LB,  32'h0000_2001, 32'h0000_0000, 2'd1, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_LH,  32'h0000_3002, 32'h0000_0000, 2'd2, 0);
        // Back-to-back loads to one line share a tag
        add_row(1, 0, 1, 0, LSU_FUNC_LW,  32'h0000_4000, 32'h0000_0000, 2'd3, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_LB,  32'h0000_4004, 32'h0000_0000, 2'd3, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_LHU, 32'h0000_4008, 32'h0000_0000, 2'd3, 0);
        // Byte, half and word stores followed by a cache hit and an idle lookup
        add_row(1, 0, 1, 0, LSU_FUNC_SB,  32'h0000_5003, 32'h0000_00EF, 2'd0, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_SH,  32'h0000_500A, 32'h0000_BEEF, 2'd0, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_LW,  32'h0000_5000, 32'h0000_0000, 2'd0, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_SW,  32'h0000_6008, 32'h1234_5678, 2'd1, 0);
        add_row(0, 0, 1, 0, LSU_FUNC_SB,  32'h0000_600D, 32'h0000_0077, 2'd1, 0);
        add_row(0, 0, 1, 1, LSU_FUNC_SW,  32'h0000_7000, 32'hDEAD_BEEF, 2'd0, 0);
        add_row(0, 0, 0, 0, LSU_FUNC_SW,  32'h0000_8000, 32'hFFFF_FFFF, 2'd0, 0);
        // With the CCU held the queue fills up and new lines are turned away
        add_row(1, 1, 1, 0, LSU_FUNC_LW,  32'h0000_9000, 32'h0000_0000, 2'd2, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_LW,  32'h0000_A000, 32'h0000_0000, 2'd3, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_LW,  32'h0000_B000, 32'h0000_0000, 2'd0, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_LW,  32'h0000_C000, 32'h0000_0000, 2'd1, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_SH,  32'h0000_A006, 32'h0000_CAFE, 2'd3, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_LW,  32'h0000_D000, 32'h0000_0000, 2'd0, 1);
        add_row(0, 1, 1, 0, LSU_FUNC_SB,  32'h0000_E001, 32'h0000_0011, 2'd0, 1);
        add_row(0, 1, 1, 0, LSU_FUNC_LB,  32'h0000_9004, 32'h0000_0000, 2'd0, 1);
        add_row(0, 0, 0, 0, LSU_FUNC_LW,  32'h0000_0000, 32'h0000_0000, 2'd0, 0);
        // The line in flight on the CCU gets a second tag
        add_row(1, 1, 1, 0, LSU_FUNC_LW,  32'h0000_F000, 32'h0000_0000, 2'd2, 0);
        add_row(0, 1, 0, 0, LSU_FUNC_LW,  32'h0000_0000, 32'h0000_0000, 2'd0, 0);
        add_row(0, 1, 0, 0, LSU_FUNC_LW,  32'h0000_0000, 32'h0000_0000, 2'd0, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_LW,  32'h0000_F004, 32'h0000_0000, 2'd3, 0);
        add_row(0, 1, 1, 0, LSU_FUNC_SB,  32'h0000_F00F, 32'h0000_005A, 2'd3, 0);
        add_row(0, 0, 0, 0, LSU_FUNC_LW,  32'h0000_0000, 32'h0000_0000, 2'd0, 0);
    endtask

    initial begin : stimulus
        i_rst                 = 1'b1;
        i_mhq_lookup_valid    = 1'b0;
        i_mhq_lookup_dc_hit   = 1'b0;
        i_mhq_lookup_addr     = '0;
        i_mhq_lookup_lsu_func = LSU_FUNC_LW;
        i_mhq_lookup_data     = '0;
        ccu_hold              = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        #10;
        i_rst = 1'b0;
        check_flag("o_ccu_en", o_ccu_en, 1'b0);
        check_flag("o_mhq_fill_en", o_mhq_fill_en, 1'b0);
        check_flag("o_mhq_lookup_full", o_mhq_lookup_full, 1'b0);

        for (int r = 0; r < num_rows; r++) begin
            if (row_drain[r]) begin
                wait_for_drain();
            end
            ccu_hold              = row_hold[r];
            i_mhq_lookup_valid    = row_valid[r];
            i_mhq_lookup_dc_hit   = row_dc_hit[r];
            i_mhq_lookup_lsu_func = row_func[r];
            i_mhq_lookup_addr     = row_addr[r];
            i_mhq_lookup_data     = row_data[r];
            @(posedge clk);
            #10;
            i_mhq_lookup_valid = 1'b0;
            if (row_valid[r] && !row_dc_hit[r]) begin
                check_flag("o_mhq_lookup_full", o_mhq_lookup_full, row_full[r]);
                if (!row_full[r]) begin
                    check_tag("o_mhq_lookup_tag", o_mhq_lookup_tag, row_tag[r]);
                    record_lookup(r);
                end
            end
        end

        // Quiet cycles at the end catch any fill nobody asked for
        wait_for_drain();
        repeat (20) @(posedge clk);
        if (sb_tag.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d expected fills never arrived", sb_tag.size()));
        end
    end

    // CCU answers each request after 1 to 8 cycles unless the table holds it
    initial begin : ccu_model
        int delay;
        i_ccu_done = 1'b0;
        i_ccu_data = '0;
        delay      = $urandom(SEED);
        forever begin
            @(posedge clk);
            #5;
            if (!i_rst && o_ccu_en) begin
                // Requests go out for the oldest open line
                if (sb_addr.size() == 0) begin
                    abort_run($sformatf("A CCU request for %h at %0t ns has no open line",
                                        o_ccu_addr, $time));
                end else begin
                    check_addr("o_ccu_addr", o_ccu_addr, sb_addr[0]);
                end
                delay = ($urandom % 8) + 1;
                repeat (delay - 1) begin
                    @(posedge clk);
                    #5;
                end
                while (ccu_hold) begin
                    @(posedge clk);
                    #5;
                end
                #5;
                i_ccu_data = memory_line(o_ccu_addr);
                i_ccu_done = 1'b1;
                @(posedge clk);
                #10;
                i_ccu_done = 1'b0;
                // The fill follows the done cycle and the request is closed
                check_flag("o_mhq_fill_en", o_mhq_fill_en, 1'b1);
                check_flag("o_ccu_en", o_ccu_en, 1'b0);
            end
        end
    end

    initial begin : fill_monitor
        forever begin
            @(posedge clk);
            #5;
            if (!i_rst && o_mhq_fill_en) begin
                check_fill();
            end
        end
    end

    initial begin : watchdog
        wait (num_rows > 0);
        #(num_rows * 20 * CLK_PERIOD);
        abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                            num_rows * 20));
    end

endmodule

/* mhq.f */
logic/mhq_pkg.sv
logic/mhq_lookup.sv
logic/mhq_execute.sv
logic/mhq_fill.sv
logic/mhq.sv
verification/mhq_tb.sv
